// ==== design/rvDecodePkg.sv ====
package rvDecodePkg;

    parameter int xlen = 32; // Datapath width

    localparam int regAddrW = 5; // Register specifier field width
    localparam int opcodeW  = 5; // Opcode bits 6 to 2
    localparam int aluOpW   = 4;
    localparam int srcAW    = 2;

    // Major opcodes, low two bits dropped
    typedef enum logic [opcodeW-1:0] {
        load   = 5'b00000,
        opImm  = 5'b00100,
        auipc  = 5'b00101,
        store  = 5'b01000,
        op     = 5'b01100,
        lui    = 5'b01101,
        branch = 5'b11000,
        jalr   = 5'b11001,
        jal    = 5'b11011,
        system = 5'b11100
    } opcode_e;

    // Execute stage operations, add must stay at zero
    typedef enum logic [aluOpW-1:0] {
        add   = 4'd0,
        sub   = 4'd1,
        sll   = 4'd2,
        slt   = 4'd3,
        sltu  = 4'd4,
        xorOp = 4'd5,
        srl   = 4'd6,
        sra   = 4'd7,
        orOp  = 4'd8,
        andOp = 4'd9,
        passB = 4'd10 // Result is operand B
    } aluOp_e;

    typedef enum logic [srcAW-1:0] {
        rs1  = 2'd0, // Register rs1
        pc   = 2'd1, // Instruction address
        zero = 2'd2  // Constant zero
    } srcA_e;

    typedef enum logic {
        rs2 = 1'b0, // Register rs2
        imm = 1'b1  // Decoded immediate
    } srcB_e;

endpackage

// ==== design/immDecoder.sv ====
`timescale 1ns/1ps

module immDecoder (
    input  logic [31:0]                  instr,
    output logic [rvDecodePkg::xlen-1:0] imm
);

    localparam int fillI = rvDecodePkg::xlen - 12; // Sign fill for 12 bit fields
    localparam int fillB = rvDecodePkg::xlen - 13;
    localparam int fillJ = rvDecodePkg::xlen - 21;
    localparam int fillU = rvDecodePkg::xlen - 32;
    localparam int fillZ = rvDecodePkg::xlen - 5; // Zero fill for 5 bit fields

    logic [4:0] opField;
    logic [2:0] funct3;
    logic [4:0] rs1Field;
    logic [4:0] shamt;
    logic       signBit;

    assign opField  = instr[6:2]; // Low bits are always 11
    assign funct3   = instr[14:12];
    assign rs1Field = instr[19:15];
    assign shamt    = instr[24:20];
    assign signBit  = instr[31];

    always_comb begin
        casez (opField)
            5'b00?00: begin // Loads and OP-IMM
                if (opField[2] && funct3[1:0] == 2'b01) begin
                    imm = {{fillZ{1'b0}}, shamt}; // SLLI, SRLI, SRAI
                end else begin
                    imm = {{fillI{signBit}}, instr[31:20]};
                end
            end
            5'b11001: begin // JALR
                imm = {{fillI{signBit}}, instr[31:20]};
            end
            5'b01000: begin // S-type
                imm = {{fillI{signBit}}, instr[31:25], instr[11:7]};
            end
            5'b11000: begin // B-type, bit 0 implied
                imm = {{fillB{signBit}}, signBit, instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            5'b0?101: begin // LUI and AUIPC
                imm = {{fillU{signBit}}, instr[31:12], 12'b0};
            end
            5'b11011: begin // J-type
                imm = {{fillJ{signBit}}, signBit, instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: begin
                // CSR immediate forms carry a 5 bit value in the rs1 slot
                imm = {{fillZ{1'b0}}, rs1Field};
            end
        endcase
    end

endmodule

// ==== design/ctrlDecoder.sv ====
`timescale 1ns/1ps

module ctrlDecoder (
    input  logic [31:0]         instr,
    output rvDecodePkg::aluOp_e aluOp,
    output rvDecodePkg::srcA_e  srcA,
    output rvDecodePkg::srcB_e  srcB,
    output logic                regWrite,
    output logic                memRead,
    output logic                memWrite,
    output logic                branch,
    output logic                jump,
    output logic                system,
    output logic                illegal
);

    rvDecodePkg::opcode_e opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic                 altBit;
    logic                 isShift;
    logic                 funct7Ok;
    logic                 opKnown;

    // Register op or shift from funct3, altBit picks sub and sra
    function automatic rvDecodePkg::aluOp_e aluFromFunct(
        input logic [2:0] f3,
        input logic       alt
    );
        rvDecodePkg::aluOp_e result;
        case (f3)
            3'b000:  result = alt ? rvDecodePkg::sub : rvDecodePkg::add;
            3'b001:  result = rvDecodePkg::sll;
            3'b010:  result = rvDecodePkg::slt;
            3'b011:  result = rvDecodePkg::sltu;
            3'b100:  result = rvDecodePkg::xorOp;
            3'b101:  result = alt ? rvDecodePkg::sra : rvDecodePkg::srl;
            3'b110:  result = rvDecodePkg::orOp;
            default: result = rvDecodePkg::andOp;
        endcase
        return result;
    endfunction

    assign opcode  = rvDecodePkg::opcode_e'(instr[6:2]);
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign altBit  = instr[30];
    assign isShift = (funct3[1:0] == 2'b01); // SLL, SRL, SRA forms

    // Only sub, sra and srai may carry funct7 0100000
    always_comb begin
        if (funct7 == 7'b0000000) begin
            funct7Ok = 1'b1;
        end else if (funct7 == 7'b0100000) begin
            funct7Ok = (funct3 == 3'b101) || (opcode == rvDecodePkg::op && funct3 == 3'b000);
        end else begin
            funct7Ok = 1'b0; // Includes M extension encodings
        end
    end

    always_comb begin
        aluOp    = rvDecodePkg::add;
        srcA     = rvDecodePkg::rs1;
        srcB     = rvDecodePkg::imm;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        branch   = 1'b0;
        jump     = 1'b0;
        system   = 1'b0;
        opKnown  = 1'b1;
        illegal  = 1'b0;

        case (opcode)
            rvDecodePkg::load: begin
                regWrite = 1'b1;
                memRead  = 1'b1;
            end
            rvDecodePkg::store: begin
                memWrite = 1'b1;
            end
            rvDecodePkg::opImm: begin
                regWrite = 1'b1;
                aluOp    = aluFromFunct(funct3, isShift & altBit); // ADDI ignores bit 30
                illegal  = isShift & ~funct7Ok;
            end
            rvDecodePkg::op: begin
                regWrite = 1'b1;
                srcB     = rvDecodePkg::rs2;
                aluOp    = aluFromFunct(funct3, altBit);
                illegal  = ~funct7Ok;
            end
            rvDecodePkg::lui: begin
                regWrite = 1'b1;
                srcA     = rvDecodePkg::zero;
                aluOp    = rvDecodePkg::passB;
            end
            rvDecodePkg::auipc: begin
                regWrite = 1'b1;
                srcA     = rvDecodePkg::pc;
            end
            rvDecodePkg::jal: begin
                regWrite = 1'b1;
                jump     = 1'b1;
                srcA     = rvDecodePkg::pc; // Target is pc plus offset
            end
            rvDecodePkg::jalr: begin
                regWrite = 1'b1;
                jump     = 1'b1;
            end
            rvDecodePkg::branch: begin
                branch = 1'b1;
                srcB   = rvDecodePkg::rs2;
                aluOp  = rvDecodePkg::sub; // Compare by subtraction
            end
            rvDecodePkg::system: begin
                system = 1'b1; // No CSR file, flag only
            end
            default: begin
                opKnown = 1'b0;
            end
        endcase

        if (!opKnown || instr[1:0] != 2'b11) begin
            illegal = 1'b1; // Unknown major opcode or compressed encoding
        end

        if (illegal) begin
            regWrite = 1'b0;
            memRead  = 1'b0;
            memWrite = 1'b0;
        end
    end

endmodule

// ==== design/regFile.sv ====
`timescale 1ns/1ps

module regFile #(
    parameter int numRegs = 32
) (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic [rvDecodePkg::regAddrW-1:0]    rs1Addr,
    input  logic [rvDecodePkg::regAddrW-1:0]    rs2Addr,
    output logic [rvDecodePkg::xlen-1:0]        rs1Data,
    output logic [rvDecodePkg::xlen-1:0]        rs2Data,
    input  logic                                wbEn,
    input  logic [rvDecodePkg::regAddrW-1:0]    wbAddr,
    input  logic [rvDecodePkg::xlen-1:0]        wbData
);

    localparam int addrW = $clog2(numRegs); // 4 for RV32E

    logic [rvDecodePkg::xlen-1:0] regs [numRegs];
    logic [addrW-1:0]             wbIdx;
    logic                         wbLive;

    assign wbIdx  = wbAddr[addrW-1:0]; // Upper address bits ignored
    assign wbLive = wbEn && (wbIdx != '0);

    // x0 first, then same-cycle writeback, then the array
    function automatic logic [rvDecodePkg::xlen-1:0] readPort(input logic [addrW-1:0] idx);
        logic [rvDecodePkg::xlen-1:0] value;
        if (idx == '0) begin
            value = '0;
        end else if (wbLive && wbIdx == idx) begin
            value = wbData;
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    always_comb begin
        rs1Data = readPort(rs1Addr[addrW-1:0]);
        rs2Data = readPort(rs2Addr[addrW-1:0]);
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wbLive) begin
            regs[wbIdx] <= wbData;
        end
    end

endmodule

// ==== design/issueReg.sv ====
`timescale 1ns/1ps

module issueReg (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             inValid,
    output logic                             inReady,
    input  logic [rvDecodePkg::xlen-1:0]     pc,
    input  logic [rvDecodePkg::xlen-1:0]     imm,
    input  logic [rvDecodePkg::xlen-1:0]     rs1Data,
    input  logic [rvDecodePkg::xlen-1:0]     rs2Data,
    input  rvDecodePkg::srcA_e               srcA,
    input  rvDecodePkg::srcB_e               srcB,
    input  rvDecodePkg::aluOp_e              aluOp,
    input  logic [rvDecodePkg::regAddrW-1:0] rd,
    input  logic [2:0]                       funct3,
    input  logic                             regWrite,
    input  logic                             memRead,
    input  logic                             memWrite,
    input  logic                             branch,
    input  logic                             jump,
    input  logic                             system,
    input  logic                             illegal,
    output logic                             outValid,
    input  logic                             outReady,
    output rvDecodePkg::aluOp_e              outAluOp,
    output logic [rvDecodePkg::xlen-1:0]     outOpA,
    output logic [rvDecodePkg::xlen-1:0]     outOpB,
    output logic [rvDecodePkg::xlen-1:0]     outImm,
    output logic [rvDecodePkg::xlen-1:0]     outStoreData,
    output logic [rvDecodePkg::regAddrW-1:0] outRd,
    output logic [2:0]                       outFunct3,
    output logic                             outRegWrite,
    output logic                             outMemRead,
    output logic                             outMemWrite,
    output logic                             outBranch,
    output logic                             outJump,
    output logic                             outSystem,
    output logic                             outIllegal
);

    logic [rvDecodePkg::xlen-1:0] opA;
    logic [rvDecodePkg::xlen-1:0] opB;
    logic                         accept;

    assign inReady = !outValid || outReady; // Empty or draining this cycle
    assign accept  = inValid && inReady;

    always_comb begin
        case (srcA)
            rvDecodePkg::rs1: opA = rs1Data;
            rvDecodePkg::pc:  opA = pc;
            default:          opA = '0; // LUI
        endcase
    end

    assign opB = (srcB == rvDecodePkg::imm) ? imm : rs2Data;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid     <= 1'b0;
            outAluOp     <= rvDecodePkg::add;
            outOpA       <= '0;
            outOpB       <= '0;
            outImm       <= '0;
            outStoreData <= '0;
            outRd        <= '0;
            outFunct3    <= '0;
            outRegWrite  <= 1'b0;
            outMemRead   <= 1'b0;
            outMemWrite  <= 1'b0;
            outBranch    <= 1'b0;
            outJump      <= 1'b0;
            outSystem    <= 1'b0;
            outIllegal   <= 1'b0;
        end else begin
            if (inReady) begin
                outValid <= inValid; // Refill or go empty
            end
            if (accept) begin
                outAluOp     <= aluOp;
                outOpA       <= opA;
                outOpB       <= opB;
                outImm       <= imm;
                outStoreData <= rs2Data; // Store value always from rs2
                outRd        <= rd;
                outFunct3    <= funct3;
                outRegWrite  <= regWrite;
                outMemRead   <= memRead;
                outMemWrite  <= memWrite;
                outBranch    <= branch;
                outJump      <= jump;
                outSystem    <= system;
                outIllegal   <= illegal;
            end
        end
    end

endmodule

// ==== design/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage #(
    parameter int numRegs = 32 // 16 for RV32E
) (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             inValid,
    output logic                             inReady,
    input  logic [31:0]                      inInstr,
    input  logic [rvDecodePkg::xlen-1:0]     inPc,
    input  logic                             wbEn,
    input  logic [rvDecodePkg::regAddrW-1:0] wbAddr,
    input  logic [rvDecodePkg::xlen-1:0]     wbData,
    output logic                             outValid,
    input  logic                             outReady,
    output rvDecodePkg::aluOp_e              outAluOp,
    output logic [rvDecodePkg::xlen-1:0]     outOpA,
    output logic [rvDecodePkg::xlen-1:0]     outOpB,
    output logic [rvDecodePkg::xlen-1:0]     outImm,
    output logic [rvDecodePkg::xlen-1:0]     outStoreData,
    output logic [rvDecodePkg::regAddrW-1:0] outRd,
    output logic [2:0]                       outFunct3,
    output logic                             outRegWrite,
    output logic                             outMemRead,
    output logic                             outMemWrite,
    output logic                             outBranch,
    output logic                             outJump,
    output logic                             outSystem,
    output logic                             outIllegal
);

    logic [rvDecodePkg::regAddrW-1:0] rdField;
    logic [rvDecodePkg::regAddrW-1:0] rs1Field;
    logic [rvDecodePkg::regAddrW-1:0] rs2Field;
    logic [2:0]                       funct3Field;

    logic [rvDecodePkg::xlen-1:0] imm;
    logic [rvDecodePkg::xlen-1:0] rs1Data;
    logic [rvDecodePkg::xlen-1:0] rs2Data;
    rvDecodePkg::aluOp_e          aluOp;
    rvDecodePkg::srcA_e           srcA;
    rvDecodePkg::srcB_e           srcB;
    logic                         regWrite;
    logic                         memRead;
    logic                         memWrite;
    logic                         branch;
    logic                         jump;
    logic                         system;
    logic                         illegal;

    assign rdField     = inInstr[11:7];
    assign funct3Field = inInstr[14:12];
    assign rs1Field    = inInstr[19:15];
    assign rs2Field    = inInstr[24:20];

    immDecoder u_immDecoder (
        .instr (inInstr),
        .imm   (imm)
    );

    ctrlDecoder u_ctrlDecoder (
        .instr    (inInstr),
        .aluOp    (aluOp),
        .srcA     (srcA),
        .srcB     (srcB),
        .regWrite (regWrite),
        .memRead  (memRead),
        .memWrite (memWrite),
        .branch   (branch),
        .jump     (jump),
        .system   (system),
        .illegal  (illegal)
    );

    regFile #(
        .numRegs (numRegs)
    ) u_regFile (
        .clk     (clk),
        .rstN    (rstN),
        .rs1Addr (rs1Field),
        .rs2Addr (rs2Field),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .wbEn    (wbEn),
        .wbAddr  (wbAddr),
        .wbData  (wbData)
    );

    issueReg u_issueReg (
        .clk          (clk),
        .rstN         (rstN),
        .inValid      (inValid),
        .inReady      (inReady),
        .pc           (inPc),
        .imm          (imm),
        .rs1Data      (rs1Data),
        .rs2Data      (rs2Data),
        .srcA         (srcA),
        .srcB         (srcB),
        .aluOp        (aluOp),
        .rd           (rdField),
        .funct3       (funct3Field),
        .regWrite     (regWrite),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .branch       (branch),
        .jump         (jump),
        .system       (system),
        .illegal      (illegal),
        .outValid     (outValid),
        .outReady     (outReady),
        .outAluOp     (outAluOp),
        .outOpA       (outOpA),
        .outOpB       (outOpB),
        .outImm       (outImm),
        .outStoreData (outStoreData),
        .outRd        (outRd),
        .outFunct3    (outFunct3),
        .outRegWrite  (outRegWrite),
        .outMemRead   (outMemRead),
        .outMemWrite  (outMemWrite),
        .outBranch    (outBranch),
        .outJump      (outJump),
        .outSystem    (outSystem),
        .outIllegal   (outIllegal)
    );

endmodule

// ==== testbench/decodeStageTb.sv ====
`timescale 1ns/1ps

module decodeStageTb;

    localparam int resetCycles   = 16;
    localparam int directedCount = 20; // Table plus the bypass case
    localparam int randomCount   = 120;
    localparam int instrCount    = directedCount + randomCount;
    localparam int watchdogNs    = 200 * (resetCycles + 32 + instrCount);

    typedef struct packed {
        logic [3:0]  aluOp;
        logic [31:0] opA;
        logic [31:0] opB;
        logic [31:0] imm;
        logic [31:0] storeData;
        logic [4:0]  rd;
        logic [2:0]  funct3;
        logic [6:0]  flags; // regWrite down to illegal
    } issueBundle_t;

    logic                clk;
    logic                rstN;
    logic                inValid;
    logic                inReady;
    logic [31:0]         inInstr;
    logic [31:0]         inPc;
    logic                wbEn;
    logic [4:0]          wbAddr;
    logic [31:0]         wbData;
    logic                outValid;
    logic                outReady;
    rvDecodePkg::aluOp_e outAluOp;
    logic [31:0]         outOpA;
    logic [31:0]         outOpB;
    logic [31:0]         outImm;
    logic [31:0]         outStoreData;
    logic [4:0]          outRd;
    logic [2:0]          outFunct3;
    logic                outRegWrite;
    logic                outMemRead;
    logic                outMemWrite;
    logic                outBranch;
    logic                outJump;
    logic                outSystem;
    logic                outIllegal;

    integer       seed      = 32'h70ab;
    integer       readySeed = 32'h70ab; // Own stream for the consumer
    logic         stallEnable;
    logic [31:0]  modelRegs [32];
    issueBundle_t expQ [$];
    issueBundle_t heldBundle;
    logic         acceptedPrev = 1'b0;
    logic         stalledPrev  = 1'b0;
    int           resetEdges   = 0;
    int           accepted     = 0;
    int           received     = 0;

    string flagNames [7] = '{"outRegWrite", "outMemRead", "outMemWrite", "outBranch",
                             "outJump", "outSystem", "outIllegal"};

    logic [31:0] directed [19] = '{
        32'h800011B7, // lui x3, 0x80001
        32'h12345217, // auipc x4, 0x12345
        32'hFF9FF0EF, // jal x1, -8
        32'hFFC102E7, // jalr x5, -4(x2)
        32'hFE7308E3, // beq x6, x7, -16
        32'h8004A403, // lw x8, -2048(x9)
        32'h7EA5AA23, // sw x10, 0x7f4(x11)
        32'hFFF68613, // addi x12, x13, -1
        32'h01F79713, // slli x14, x15, 31
        32'h4078D813, // srai x16, x17, 7
        32'h01498933, // add x18, x19, x20
        32'h417B0AB3, // sub x21, x22, x23
        32'h41ACDC33, // sra x24, x25, x26
        32'h300AD0F3, // csrrwi x1, 0x300, 21
        32'h000002B3, // add x5, x0, x0
        32'h0000000B, // custom-0, unknown opcode
        32'hFFF68610, // addi with low bits 00
        32'h023100B3, // mul, M extension
        32'h41F79713  // slli with funct7 0100000
    };

    rvDecodePkg::opcode_e legalOps [10] = '{rvDecodePkg::load, rvDecodePkg::opImm,
        rvDecodePkg::auipc, rvDecodePkg::store, rvDecodePkg::op, rvDecodePkg::lui,
        rvDecodePkg::branch, rvDecodePkg::jalr, rvDecodePkg::jal, rvDecodePkg::system};

    decodeStage #(
        .numRegs (32)
    ) u_decodeStage (
        .clk          (clk),
        .rstN         (rstN),
        .inValid      (inValid),
        .inReady      (inReady),
        .inInstr      (inInstr),
        .inPc         (inPc),
        .wbEn         (wbEn),
        .wbAddr       (wbAddr),
        .wbData       (wbData),
        .outValid     (outValid),
        .outReady     (outReady),
        .outAluOp     (outAluOp),
        .outOpA       (outOpA),
        .outOpB       (outOpB),
        .outImm       (outImm),
        .outStoreData (outStoreData),
        .outRd        (outRd),
        .outFunct3    (outFunct3),
        .outRegWrite  (outRegWrite),
        .outMemRead   (outMemRead),
        .outMemWrite  (outMemWrite),
        .outBranch    (outBranch),
        .outJump      (outJump),
        .outSystem    (outSystem),
        .outIllegal   (outIllegal)
    );

    always #4 clk = ~clk; // 8 ns period

    task automatic failRun(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic failValue(input string name, input logic [31:0] got, input logic [31:0] want);
        failRun($sformatf("[ERROR] t=%0t %s got %h expected %h", $time, name, got, want));
    endtask

    task automatic checkField(input string name, input logic [31:0] got, input logic [31:0] want);
        assert (got === want) else failValue(name, got, want);
    endtask

    // ISA table for OP and the OP-IMM shift forms
    function automatic logic [3:0] aluForFunct3(input logic [2:0] f3, input logic alt);
        logic [3:0] code;
        case (f3)
            3'b000:  code = alt ? rvDecodePkg::sub : rvDecodePkg::add;
            3'b001:  code = rvDecodePkg::sll;
            3'b010:  code = rvDecodePkg::slt;
            3'b011:  code = rvDecodePkg::sltu;
            3'b100:  code = rvDecodePkg::xorOp;
            3'b101:  code = alt ? rvDecodePkg::sra : rvDecodePkg::srl;
            3'b110:  code = rvDecodePkg::orOp;
            default: code = rvDecodePkg::andOp;
        endcase
        return code;
    endfunction

    function automatic logic funct7Legal(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic regOp);
        return (f7 == 7'b0000000) ||
               (f7 == 7'b0100000 && (f3 == 3'b101 || (regOp && f3 == 3'b000)));
    endfunction

    function automatic logic [31:0] readModelReg(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return 32'd0;
        end
        if (wbEn && wbAddr == addr) begin
            return wbData; // Same-cycle write is forwarded
        end
        return modelRegs[addr];
    endfunction

    function automatic issueBundle_t expectBundle(input logic [31:0] instr,
                                                  input logic [31:0] pcVal,
                                                  input logic [31:0] r1,
                                                  input logic [31:0] r2);
        issueBundle_t e;
        logic [4:0]   op5;
        logic [2:0]   f3;
        logic         shiftImm;
        logic         known;
        logic         rw;
        logic         mr;
        logic         mw;
        logic         br;
        logic         jp;
        logic         sy;
        logic         il;
        op5      = instr[6:2];
        f3       = instr[14:12];
        shiftImm = (op5 == rvDecodePkg::opImm) && (f3 == 3'b001 || f3 == 3'b101);
        known    = 1'b1;
        {rw, mr, mw, br, jp, sy, il} = 7'b0;
        e.aluOp  = rvDecodePkg::add;
        e.opA    = r1;
        e.imm    = {27'b0, instr[19:15]}; // CSR immediate unless a format matches
        case (op5)
            rvDecodePkg::load: begin
                e.imm = {{20{instr[31]}}, instr[31:20]};
                rw    = 1'b1;
                mr    = 1'b1;
            end
            rvDecodePkg::opImm: begin
                e.imm   = shiftImm ? {27'b0, instr[24:20]} : {{20{instr[31]}}, instr[31:20]};
                e.aluOp = aluForFunct3(f3, shiftImm && instr[30]);
                rw      = 1'b1;
                il      = shiftImm && !funct7Legal(instr[31:25], f3, 1'b0);
            end
            rvDecodePkg::auipc: begin
                e.imm = {instr[31:12], 12'b0};
                e.opA = pcVal;
                rw    = 1'b1;
            end
            rvDecodePkg::store: begin
                e.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                mw    = 1'b1;
            end
            rvDecodePkg::op: begin
                e.aluOp = aluForFunct3(f3, instr[30]);
                rw      = 1'b1;
                il      = !funct7Legal(instr[31:25], f3, 1'b1);
            end
            rvDecodePkg::lui: begin
                e.imm   = {instr[31:12], 12'b0};
                e.opA   = 32'd0;
                e.aluOp = rvDecodePkg::passB;
                rw      = 1'b1;
            end
            rvDecodePkg::branch: begin
                e.imm   = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
                e.aluOp = rvDecodePkg::sub;
                br      = 1'b1;
            end
            rvDecodePkg::jalr: begin
                e.imm = {{20{instr[31]}}, instr[31:20]};
                rw    = 1'b1;
                jp    = 1'b1;
            end
            rvDecodePkg::jal: begin
                e.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
                e.opA = pcVal;
                rw    = 1'b1;
                jp    = 1'b1;
            end
            rvDecodePkg::system: sy = 1'b1;
            default:             known = 1'b0;
        endcase
        e.opB = (op5 == rvDecodePkg::op || op5 == rvDecodePkg::branch) ? r2 : e.imm;
        if (!known || instr[1:0] != 2'b11) begin
            il = 1'b1;
        end
        if (il) begin
            rw = 1'b0;
            mr = 1'b0;
            mw = 1'b0;
        end
        e.storeData = r2;
        e.rd        = instr[11:7];
        e.funct3    = f3;
        e.flags     = {rw, mr, mw, br, jp, sy, il};
        return e;
    endfunction

    function automatic issueBundle_t sampleOutputs();
        issueBundle_t s;
        s.aluOp     = outAluOp;
        s.opA       = outOpA;
        s.opB       = outOpB;
        s.imm       = outImm;
        s.storeData = outStoreData;
        s.rd        = outRd;
        s.funct3    = outFunct3;
        s.flags     = {outRegWrite, outMemRead, outMemWrite, outBranch, outJump, outSystem,
                       outIllegal};
        return s;
    endfunction

    task automatic compareBundle(input issueBundle_t want);
        issueBundle_t got;
        int           i;
        got = sampleOutputs();
        checkField("outAluOp", 32'(got.aluOp), 32'(want.aluOp));
        checkField("outOpA", got.opA, want.opA);
        checkField("outOpB", got.opB, want.opB);
        checkField("outImm", got.imm, want.imm);
        checkField("outStoreData", got.storeData, want.storeData);
        checkField("outRd", 32'(got.rd), 32'(want.rd));
        checkField("outFunct3", 32'(got.funct3), 32'(want.funct3));
        for (i = 0; i < 7; i++) begin
            checkField(flagNames[i], 32'(got.flags[6-i]), 32'(want.flags[6-i]));
        end
    endtask

    // Caller sits on a rising edge, returns on the edge of the write
    task automatic writeReg(input logic [4:0] addr, input logic [31:0] data);
        wbEn   <= 1'b1;
        wbAddr <= addr;
        wbData <= data;
        @(posedge clk);
    endtask

    // Returns on the accepting edge so the next instruction follows back to back
    task automatic sendInstr(input logic [31:0] instr, input logic [31:0] pcVal,
                             input logic doWb, input logic [4:0] wa, input logic [31:0] wd);
        inValid <= 1'b1;
        inInstr <= instr;
        inPc    <= pcVal;
        wbEn    <= doWb;
        wbAddr  <= wa;
        wbData  <= wd;
        @(posedge clk);
        wbEn <= 1'b0; // Writeback lasts one cycle
        while (!inReady) begin
            @(posedge clk);
        end
    endtask

    always @(posedge clk) begin
        if (stallEnable) begin
            outReady <= (($random(readySeed) & 3) != 0); // Low about one cycle in four
        end else begin
            outReady <= 1'b1;
        end
    end

    // Reference model and output checks
    always @(posedge clk) begin
        issueBundle_t want;
        int           r;
        if (!rstN) begin
            if (resetEdges > 0) begin
                assert (outValid === 1'b0) else failValue("outValid", 32'(outValid), 32'd0);
            end
            resetEdges++;
            acceptedPrev = 1'b0;
            stalledPrev  = 1'b0;
            for (r = 0; r < 32; r++) begin
                modelRegs[r] = 32'd0;
            end
        end else begin
            if (acceptedPrev) begin
                assert (outValid === 1'b1)
                    else failRun("Accepted instruction not on the outputs one cycle later");
            end
            if (stalledPrev) begin
                assert (outValid === 1'b1) else failValue("outValid", 32'(outValid), 32'd1);
                compareBundle(heldBundle); // Held through back-pressure
            end
            assert (inReady === (expQ.size() == 0 || outReady))
                else failValue("inReady", 32'(inReady), 32'(expQ.size() == 0 || outReady));
            if (outValid && outReady) begin
                if (expQ.size() == 0) begin
                    failRun("An output transfer happened with no instruction outstanding");
                end else begin
                    want = expQ.pop_front();
                    compareBundle(want);
                    received++;
                end
            end
            acceptedPrev = inValid && inReady;
            if (acceptedPrev) begin
                expQ.push_back(expectBundle(inInstr, inPc, readModelReg(inInstr[19:15]),
                                            readModelReg(inInstr[24:20])));
                accepted++;
            end
            if (wbEn && wbAddr != 5'd0) begin
                modelRegs[wbAddr] = wbData;
            end
            stalledPrev = outValid && !outReady;
            heldBundle  = sampleOutputs();
        end
    end

    initial begin
        int          i;
        int          idx;
        logic [31:0] rnd;
        logic [31:0] wbRnd;
        clk         = 1'b0;
        rstN        = 1'b0;
        inValid     = 1'b0;
        inInstr     = 32'd0;
        inPc        = 32'd0;
        wbEn        = 1'b0;
        wbAddr      = 5'd0;
        wbData      = 32'd0;
        outReady    = 1'b0;
        stallEnable = 1'b0;
        repeat (resetCycles) @(posedge clk);
        rstN        <= 1'b1;
        stallEnable <= 1'b1;
        for (i = 0; i < 32; i++) begin
            writeReg(5'(i), $random(seed)); // x0 too, must still read zero
        end
        wbEn <= 1'b0;
        for (i = 0; i < 19; i++) begin
            sendInstr(directed[i], 32'h8000_0000 + 32'(i * 4), 1'b0, 5'd0, 32'd0);
        end
        // add x18, x19, x20 while x19 is written in the same cycle
        sendInstr(32'h01498933, 32'h8000_0100, 1'b1, 5'd19, 32'hcafe_0019);
        for (i = 0; i < randomCount; i++) begin
            rnd   = $random(seed);
            wbRnd = $random(seed);
            idx   = int'(rnd[6:3]) % 10;
            sendInstr({rnd[31:7], legalOps[idx], 2'b11}, 32'h0001_0000 + 32'(i * 4),
                      wbRnd[0], wbRnd[5:1], $random(seed));
        end
        inValid     <= 1'b0;
        stallEnable <= 1'b0;
        while (received < instrCount) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk); // Catch a late duplicate
        if (accepted == instrCount && received == instrCount && expQ.size() == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            failRun($sformatf("Transfer count mismatch, accepted %0d received %0d planned %0d",
                              accepted, received, instrCount));
        end
    end

    initial begin
        #(watchdogNs);
        failRun("Watchdog timeout, the test did not finish in time");
    end

endmodule

// ==== flist.f ====
design/rvDecodePkg.sv
design/immDecoder.sv
design/ctrlDecoder.sv
design/regFile.sv
design/issueReg.sv
design/decodeStage.sv
testbench/decodeStageTb.sv

// ==== Makefile ====
TOP   = decodeStageTb
BUILD = build

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check for the pass line"
	@echo "  clean  remove the build folder"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		--Mdir $(BUILD) -f flist.f
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(BUILD)
